// ==== list.f ====
source/soc_pkg.sv
source/addr_decode.sv
source/boot_memory.sv
source/button_port.sv
source/cycle_timer.sv
source/uart_receiver.sv
source/reset_sequencer.sv
source/soc_top.sv
sim/soc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module soc_tb -f list.f -o soc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/soc_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

// ==== sim/soc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_tb;
    import soc_pkg::*;

    // clocks per uart bit, divided timer rate, release interval
    localparam int UART_BIT   = 16;
    localparam int SLOW_DIV   = 27;
    localparam int DEBOUNCE   = 64;
    localparam int MAX_CYCLES = 20000;
    localparam int MODEL_WORDS = 16;

    localparam logic [31:0] BTN_ADDR   = {REGION_BTN, 28'h0};
    localparam logic [31:0] UART_ADDR  = {REGION_UART, 28'h0};
    localparam logic [31:0] FAST_ADDR  = {REGION_TIMER, 28'h0};
    localparam logic [31:0] SLOW_ADDR  = {REGION_TIMER, 28'h4};
    localparam logic [31:0] NONE_ADDR  = {4'h5, 28'h10};

    logic        clkout = 1'b0;
    logic        rst;
    logic [31:0] pc;
    logic [31:0] data_addr;
    logic [31:0] wdata;
    logic        ren;
    logic        wen;
    logic [3:0]  byte_sel;
    logic [31:0] instr;
    logic [31:0] rdata;
    logic        ready;
    logic        core_rst;
    logic        uart_rx;
    logic        btn1;
    logic        btn2;
    logic        btn_down_l;
    logic        btn_down_r;
    logic        btn_up_l;
    logic        btn_up_r;
    logic        btn_left_l;
    logic        btn_left_r;
    logic        btn_right_l;
    logic        btn_right_r;
    logic [5:0]  led;

    int          errors = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state = 32'd38596;

    // reference image of the words the test touches
    bus_word_u   mem_model [MODEL_WORDS];
    bus_word_u   dw;
    logic [31:0] rd;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] s0;
    logic [31:0] s1;
    logic [3:0]  mask;
    logic [7:0]  b0;
    logic [7:0]  b1;
    int          k;
    int          n;
    int          c0;
    int          c1;
    int          c2;
    int          c3;
    int          stamp;

    soc_top dut (
        .clkout      (clkout),
        .rst         (rst),
        .pc          (pc),
        .data_addr   (data_addr),
        .wdata       (wdata),
        .ren         (ren),
        .wen         (wen),
        .byte_sel    (byte_sel),
        .instr       (instr),
        .rdata       (rdata),
        .ready       (ready),
        .core_rst    (core_rst),
        .uart_rx     (uart_rx),
        .btn1        (btn1),
        .btn2        (btn2),
        .btn_down_l  (btn_down_l),
        .btn_down_r  (btn_down_r),
        .btn_up_l    (btn_up_l),
        .btn_up_r    (btn_up_r),
        .btn_left_l  (btn_left_l),
        .btn_left_r  (btn_left_r),
        .btn_right_l (btn_right_l),
        .btn_right_r (btn_right_r),
        .led         (led)
    );

    // 100 ns period
    always #50 clkout = ~clkout;

    // cycle count, also the run limit
    always @(posedge clkout) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("errors: %0d", errors);
            $display("Errors found");
            $finish;
        end
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // model word k sits at word 5k+2, spreads pc bits 6..2
    function automatic logic [31:0] mem_addr(input int idx);
        return 32'(idx * 20 + 8);
    endfunction

    // pin order down_l down_r up_l up_r left_l left_r right_l right_r
    function automatic logic [31:0] pressed_mask(input logic [7:0] pins);
        return {28'd0, ~pins[7] & ~pins[6], ~pins[5] & ~pins[4],
                ~pins[3] & ~pins[2], ~pins[1] & ~pins[0]};
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            errors++;
            $display("Mismatch at %0t: %s", $time, what);
        end
    endtask

    // drop the strobe after one cycle, then look for ready
    task automatic finish_access(input string what);
        int cnt;
        cnt = 0;
        do begin
            @(posedge clkout);
            #1;
            ren = 1'b0;
            wen = 1'b0;
            cnt++;
        end while (!ready && cnt < 4);
        if (!ready) begin
            errors++;
            $display("no ready pulse came back for the %s access at %0t", what, $time);
        end else begin
            check_true(cnt == 1, $sformatf("%s ready after %0d cycles", what, cnt));
        end
    endtask

    task automatic core_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clkout);
        #1;
        data_addr = addr;
        ren = 1'b1;
        finish_access("read");
        data = rdata;
    endtask

    task automatic core_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] sel);
        @(posedge clkout);
        #1;
        data_addr = addr;
        wdata = data;
        byte_sel = sel;
        wen = 1'b1;
        finish_access("write");
    endtask

    // 8N1 frame, lsb first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int j = 0; j < 10; j++) begin
            uart_rx = frame[j];
            repeat (UART_BIT) begin
                @(posedge clkout);
                #1;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        pc = '0;
        data_addr = '0;
        wdata = '0;
        ren = 1'b0;
        wen = 1'b0;
        byte_sel = '0;
        uart_rx = 1'b1;
        btn1 = 1'b1;
        btn2 = 1'b1;
        {btn_down_l, btn_down_r, btn_up_l, btn_up_r} = 4'hf;
        {btn_left_l, btn_left_r, btn_right_l, btn_right_r} = 4'hf;
        repeat (8) @(posedge clkout);
        #1;
        rst = 1'b0;
        @(posedge clkout);
        #1;
        check_true(!core_rst && !ready, "core_rst or ready active after reset");

        // memory, full words first so every model lane is known
        for (int i = 0; i < MODEL_WORDS; i++) begin
            rd = next_random();
            core_write(mem_addr(i), rd, 4'hf);
            mem_model[i].word = rd;
        end
        for (int it = 0; it < 40; it++) begin
            k = int'(next_random() % 32'd16);
            dw.word = next_random();
            mask = 4'(next_random());
            core_write(mem_addr(k), dw.word, mask);
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) begin
                    mem_model[k].lane[i] = dw.lane[i];
                end
            end
            core_read(mem_addr(k), rd);
            check_word(rd, mem_model[k].word, "memory readback");
        end
        for (int i = 0; i < MODEL_WORDS; i++) begin
            core_read(mem_addr(i), rd);
            check_word(rd, mem_model[i].word, "memory sweep");
        end
        // unmapped space completes with zero
        core_write(NONE_ADDR, 32'hdead_beef, 4'hf);
        core_read(NONE_ADDR, rd);
        check_word(rd, 32'd0, "unmapped read");

        // fetch port and leds
        for (int i = 0; i < MODEL_WORDS; i++) begin
            @(posedge clkout);
            #1;
            pc = mem_addr(i);
            @(posedge clkout);
            #1;
            check_word(instr, mem_model[i].word, "instruction fetch");
            @(posedge clkout);
            #1;
            check_word({26'd0, led}, {26'd0, 1'b0, ~pc[6:2]}, "led pattern");
        end

        // buttons
        for (int it = 0; it < 12; it++) begin
            rd = next_random();
            {btn_down_l, btn_down_r, btn_up_l, btn_up_r} = rd[7:4];
            {btn_left_l, btn_left_r, btn_right_l, btn_right_r} = rd[3:0];
            repeat (3) @(posedge clkout);
            core_read(BTN_ADDR, f0);
            check_word(f0, pressed_mask(rd[7:0]), "button mask");
        end
        {btn_down_l, btn_down_r, btn_up_l, btn_up_r} = 4'hf;
        {btn_left_l, btn_left_r, btn_right_l, btn_right_r} = 4'hf;

        // uart single bytes, then a read clears valid
        for (int it = 0; it < 4; it++) begin
            b0 = 8'(next_random());
            send_byte(b0);
            core_read(UART_ADDR, rd);
            check_word(rd, {23'd0, 1'b1, b0}, "uart byte");
            core_read(UART_ADDR, rd);
            check_true(rd[8] == 1'b0, "uart valid still set after read");
        end
        // overrun keeps the newer byte
        b0 = 8'(next_random());
        b1 = 8'(next_random());
        send_byte(b0);
        send_byte(b1);
        core_read(UART_ADDR, rd);
        check_word(rd, {23'd0, 1'b1, b1}, "uart overrun byte");

        // timers against the testbench cycle count
        for (int it = 0; it < 4; it++) begin
            core_read(FAST_ADDR, f0);
            c0 = cycle_count;
            core_read(SLOW_ADDR, s0);
            c1 = cycle_count;
            n = int'(next_random() % 32'd200) + 30;
            repeat (n) @(posedge clkout);
            core_read(FAST_ADDR, f1);
            c2 = cycle_count;
            core_read(SLOW_ADDR, s1);
            c3 = cycle_count;
            check_word(f1 - f0, 32'(c2 - c0), "fast timer delta");
            check_true(int'(s1 - s0) >= (c3 - c1) / SLOW_DIV
                       && int'(s1 - s0) <= (c3 - c1 + SLOW_DIV - 1) / SLOW_DIV,
                       $sformatf("slow timer moved %0d over %0d cycles",
                                 int'(s1 - s0), c3 - c1));
        end

        // reset sequencer, press btn1
        btn1 = 1'b0;
        n = 0;
        do begin
            @(posedge clkout);
            #1;
            n++;
        end while (!core_rst && n < 10);
        if (!core_rst) begin
            errors++;
            $display("core reset did not rise after btn1 was pressed");
        end else begin
            // one cycle plus two synchronizer flops
            check_true(n <= 3, $sformatf("core_rst rose %0d cycles after btn1", n));
        end
        repeat (20) @(posedge clkout);
        #1;
        // led 5 mirrors core reset one cycle late
        check_true(led[5], "led 5 low while core reset is held");
        btn1 = 1'b1;
        repeat (10) @(posedge clkout);
        #1;
        // short bounce on btn2 restarts the interval
        btn2 = 1'b0;
        repeat (5) @(posedge clkout);
        #1;
        btn2 = 1'b1;
        check_true(core_rst, "core_rst dropped while buttons bounced");
        n = 0;
        do begin
            @(posedge clkout);
            #1;
            n++;
        end while (core_rst && n < 200);
        if (core_rst) begin
            errors++;
            $display("core reset never released after both buttons went high");
        end else begin
            check_true(n >= DEBOUNCE && n <= DEBOUNCE + 2,
                       $sformatf("core_rst released %0d cycles after buttons", n));
        end
        // timers restarted at release
        stamp = cycle_count;
        core_read(FAST_ADDR, rd);
        check_word(rd, 32'(cycle_count - stamp - 1), "fast timer after core reset");
        core_read(SLOW_ADDR, rd);
        check_word(rd, 32'd0, "slow timer after core reset");
        // memory survives core reset
        for (int i = 0; i < MODEL_WORDS; i++) begin
            core_read(mem_addr(i), rd);
            check_word(rd, mem_model[i].word, "memory after core reset");
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/soc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_top #(
    parameter int MEM_WORDS_BITS    = soc_pkg::MEM_WORDS_BITS,
    parameter int TIMER_FAST_DIV    = soc_pkg::TIMER_FAST_DIV,
    parameter int TIMER_SLOW_DIV    = soc_pkg::TIMER_SLOW_DIV,
    parameter int UART_CLKS_PER_BIT = soc_pkg::UART_CLKS_PER_BIT,
    parameter int DEBOUNCE_CYCLES   = soc_pkg::DEBOUNCE_CYCLES
) (
    input  logic        clkout,
    input  logic        rst,
    input  logic [31:0] pc,
    input  logic [31:0] data_addr,
    input  logic [31:0] wdata,
    input  logic        ren,
    input  logic        wen,
    input  logic [3:0]  byte_sel,
    output logic [31:0] instr,
    output logic [31:0] rdata,
    output logic        ready,
    output logic        core_rst,
    input  logic        uart_rx,
    input  logic        btn1,
    input  logic        btn2,
    input  logic        btn_down_l,
    input  logic        btn_down_r,
    input  logic        btn_up_l,
    input  logic        btn_up_r,
    input  logic        btn_left_l,
    input  logic        btn_left_r,
    input  logic        btn_right_l,
    input  logic        btn_right_r,
    output logic [5:0]  led
);
    logic        mem_ren;
    logic        mem_wen;
    logic        btn_ren;
    logic        uart_ren;
    logic        timer_ren;
    logic [31:0] mem_rdata;
    logic [31:0] btn_rdata;
    logic [31:0] uart_rdata;
    logic [31:0] fast_count;
    logic [31:0] slow_count;
    logic [31:0] fast_snap;
    logic [31:0] slow_snap;
    logic        periph_rst;

    // peripherals restart with the core, memory keeps its contents
    assign periph_rst = rst || core_rst;

    addr_decode u_addr_decode (
        .clkout     (clkout),
        .rst        (rst),
        .core_rst   (core_rst),
        .data_addr  (data_addr),
        .ren        (ren),
        .wen        (wen),
        .mem_rdata  (mem_rdata),
        .btn_rdata  (btn_rdata),
        .uart_rdata (uart_rdata),
        .timer_fast (fast_snap),
        .timer_slow (slow_snap),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .btn_ren    (btn_ren),
        .uart_ren   (uart_ren),
        .timer_ren  (timer_ren),
        .rdata      (rdata),
        .ready      (ready)
    );

    boot_memory #(
        .MEM_WORDS_BITS (MEM_WORDS_BITS)
    ) u_boot_memory (
        .clkout    (clkout),
        .pc_word   (pc[MEM_WORDS_BITS+1:2]),
        .data_word (data_addr[MEM_WORDS_BITS+1:2]),
        .ren       (mem_ren),
        .wen       (mem_wen),
        .wdata     (wdata),
        .byte_sel  (byte_sel),
        .instr     (instr),
        .rdata     (mem_rdata)
    );

    button_port u_button_port (
        .clkout      (clkout),
        .rst         (rst),
        .btn_down_l  (btn_down_l),
        .btn_down_r  (btn_down_r),
        .btn_up_l    (btn_up_l),
        .btn_up_r    (btn_up_r),
        .btn_left_l  (btn_left_l),
        .btn_left_r  (btn_left_r),
        .btn_right_l (btn_right_l),
        .btn_right_r (btn_right_r),
        .ren         (btn_ren),
        .rdata       (btn_rdata)
    );

    uart_receiver #(
        .CLKS_PER_BIT (UART_CLKS_PER_BIT)
    ) u_uart_receiver (
        .clkout  (clkout),
        .rst     (periph_rst),
        .uart_rx (uart_rx),
        .ren     (uart_ren),
        .rdata   (uart_rdata)
    );

    reset_sequencer #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_reset_sequencer (
        .clkout   (clkout),
        .rst      (rst),
        .btn1     (btn1),
        .btn2     (btn2),
        .core_rst (core_rst)
    );

    // full rate count
    cycle_timer #(
        .DIVISION (TIMER_FAST_DIV)
    ) u_timer_fast (
        .clkout (clkout),
        .rst    (periph_rst),
        .count  (fast_count)
    );

    // divided count
    cycle_timer #(
        .DIVISION (TIMER_SLOW_DIV)
    ) u_timer_slow (
        .clkout (clkout),
        .rst    (periph_rst),
        .count  (slow_count)
    );

    // timer read word, both counts frozen at the strobe
    always_ff @(posedge clkout) begin
        if (timer_ren) begin
            fast_snap <= fast_count;
            slow_snap <= slow_count;
        end
    end

    // status leds, low pc bits inverted and core reset on bit 5
    always_ff @(posedge clkout) begin
        if (rst) begin
            led <= '0;
        end else begin
            led <= {core_rst, ~pc[6:2]};
        end
    end

endmodule

`default_nettype wire

// ==== source/reset_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer #(
    parameter int DEBOUNCE_CYCLES = soc_pkg::DEBOUNCE_CYCLES
) (
    input  logic clkout,
    input  logic rst,
    input  logic btn1,
    input  logic btn2,
    output logic core_rst
);
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    localparam logic ST_RUN  = 1'b0;
    localparam logic ST_HOLD = 1'b1;

    logic             state;
    logic [CNT_W-1:0] release_cnt;
    logic [1:0]       btn_sync_1;
    logic [1:0]       btn_sync_2;
    logic             any_low;

    // buttons idle high
    always_ff @(posedge clkout) begin
        if (rst) begin
            btn_sync_1 <= 2'b11;
            btn_sync_2 <= 2'b11;
        end else begin
            btn_sync_1 <= {btn2, btn1};
            btn_sync_2 <= btn_sync_1;
        end
    end

    assign any_low = ~&btn_sync_2;

    // hold until both buttons stay released long enough
    always_ff @(posedge clkout) begin
        if (rst) begin
            state       <= ST_RUN;
            release_cnt <= '0;
        end else if (state == ST_RUN) begin
            release_cnt <= '0;
            if (any_low) begin
                state <= ST_HOLD;
            end
        end else if (any_low) begin
            // bounce restarts the interval
            release_cnt <= '0;
        end else if (release_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            state <= ST_RUN;
        end else begin
            release_cnt <= release_cnt + CNT_W'(1);
        end
    end

    assign core_rst = (state == ST_HOLD);

endmodule

`default_nettype wire

// ==== source/uart_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_receiver #(
    parameter int CLKS_PER_BIT = soc_pkg::UART_CLKS_PER_BIT
) (
    input  logic        clkout,
    input  logic        rst,
    input  logic        uart_rx,
    input  logic        ren,
    output logic [31:0] rdata
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    // receive fsm states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic [1:0]       state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic [7:0]       hold;
    logic             valid;
    logic             rx_sync_1;
    logic             rx_sync_2;

    // line idles high, so the synchronizer resets to one
    always_ff @(posedge clkout) begin
        if (rst) begin
            rx_sync_1 <= 1'b1;
            rx_sync_2 <= 1'b1;
        end else begin
            rx_sync_1 <= uart_rx;
            rx_sync_2 <= rx_sync_1;
        end
    end

    always_ff @(posedge clkout) begin
        if (rst) begin
            state   <= ST_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid   <= 1'b0;
        end else begin
            // read clears the flag, a byte landing now sets it again below
            if (ren) begin
                valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync_2) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    // half a bit in, recheck the start bit
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync_2 ? ST_IDLE : ST_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                ST_DATA: begin
                    // mid-bit sample, lsb first
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        shift   <= {rx_sync_2, shift[7:1]};
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                ST_STOP: begin
                    // stop bit midpoint, a low line drops the frame
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        state   <= ST_IDLE;
                        if (rx_sync_2) begin
                            hold  <= shift;
                            valid <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
            endcase
        end
    end

    // read word, valid in bit 8 and the byte below it
    always_ff @(posedge clkout) begin
        if (ren) begin
            rdata <= {23'd0, valid, hold};
        end
    end

endmodule

`default_nettype wire

// ==== source/cycle_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cycle_timer #(
    parameter int DIVISION = soc_pkg::TIMER_FAST_DIV
) (
    input  logic        clkout,
    input  logic        rst,
    output logic [31:0] count
);
    // at least one bit, so a divisor of 1 still builds
    localparam int PRESC_W = (DIVISION > 1) ? $clog2(DIVISION) : 1;

    logic [PRESC_W-1:0] prescaler;

    // count steps when the prescaler wraps
    always_ff @(posedge clkout) begin
        if (rst) begin
            prescaler <= '0;
            count     <= '0;
        end else if (prescaler == PRESC_W'(DIVISION - 1)) begin
            prescaler <= '0;
            count     <= count + 32'd1;
        end else begin
            prescaler <= prescaler + PRESC_W'(1);
        end
    end

endmodule

`default_nettype wire

// ==== source/button_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module button_port (
    input  logic        clkout,
    input  logic        rst,
    input  logic        btn_down_l,
    input  logic        btn_down_r,
    input  logic        btn_up_l,
    input  logic        btn_up_r,
    input  logic        btn_left_l,
    input  logic        btn_left_r,
    input  logic        btn_right_l,
    input  logic        btn_right_r,
    input  logic        ren,
    output logic [31:0] rdata
);
    logic [3:0] pressed_raw;
    logic [3:0] sync_1;
    logic [3:0] sync_2;

    // active low pins, a direction counts only with both halves down
    // bit order down, up, left, right
    assign pressed_raw = {
        ~btn_down_l  & ~btn_down_r,
        ~btn_up_l    & ~btn_up_r,
        ~btn_left_l  & ~btn_left_r,
        ~btn_right_l & ~btn_right_r
    };

    // two flop synchronizer
    always_ff @(posedge clkout) begin
        if (rst) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= pressed_raw;
            sync_2 <= sync_1;
        end
    end

    // read word, mask in the low nibble
    always_ff @(posedge clkout) begin
        if (ren) begin
            rdata <= {28'd0, sync_2};
        end
    end

endmodule

`default_nettype wire

// ==== source/boot_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module boot_memory #(
    parameter int MEM_WORDS_BITS = soc_pkg::MEM_WORDS_BITS
) (
    input  logic                      clkout,
    input  logic [MEM_WORDS_BITS-1:0] pc_word,
    input  logic [MEM_WORDS_BITS-1:0] data_word,
    input  logic                      ren,
    input  logic                      wen,
    input  logic [31:0]               wdata,
    input  logic [3:0]                byte_sel,
    output logic [31:0]               instr,
    output logic [31:0]               rdata
);
    import soc_pkg::*;

    localparam int DEPTH = 2 ** MEM_WORDS_BITS;

    // word array, each entry addressable by lane
    bus_word_u mem [DEPTH];

    // write data split into lanes
    bus_word_u wdata_u;

    bus_word_u instr_u;
    bus_word_u rdata_u;

    always_comb begin
        wdata_u.word = wdata;
    end

    // instruction port
    // no strobe, follows pc one cycle later
    always_ff @(posedge clkout) begin
        instr_u <= mem[pc_word];
    end

    // data port read
    // captured on the strobe, held until the next read
    // same-cycle write to the word still gives the old value
    always_ff @(posedge clkout) begin
        if (ren) begin
            rdata_u <= mem[data_word];
        end
    end

    // data port write
    // only the lanes flagged in byte_sel change
    always_ff @(posedge clkout) begin
        if (wen) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_sel[i]) begin
                    mem[data_word].lane[i] <= wdata_u.lane[i];
                end
            end
        end
    end

    // both ports leave as whole words
    assign instr = instr_u.word;
    assign rdata = rdata_u.word;

endmodule

`default_nettype wire

// ==== source/addr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_decode (
    input  logic        clkout,
    input  logic        rst,
    input  logic        core_rst,
    input  logic [31:0] data_addr,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] mem_rdata,
    input  logic [31:0] btn_rdata,
    input  logic [31:0] uart_rdata,
    input  logic [31:0] timer_fast,
    input  logic [31:0] timer_slow,
    output logic        mem_ren,
    output logic        mem_wen,
    output logic        btn_ren,
    output logic        uart_ren,
    output logic        timer_ren,
    output logic [31:0] rdata,
    output logic        ready
);
    import soc_pkg::*;

    region_e     region;
    region_e     region_q;
    logic [1:0]  offset_q;
    logic        read_q;
    logic [31:0] read_word;

    // region from the top nibble, anything unknown is unmapped
    always_comb begin
        case (data_addr[31:28])
            4'h0:    region = REGION_MEM;
            4'h1:    region = REGION_BTN;
            4'h2:    region = REGION_UART;
            4'h3:    region = REGION_TIMER;
            default: region = REGION_NONE;
        endcase
    end

    // strobes follow the core pulse in the same cycle
    assign mem_ren   = ren && (region == REGION_MEM);
    assign mem_wen   = wen && (region == REGION_MEM);
    assign btn_ren   = ren && (region == REGION_BTN);
    assign uart_ren  = ren && (region == REGION_UART);
    assign timer_ren = ren && (region == REGION_TIMER);

    // one access in flight, ready exactly one cycle later
    always_ff @(posedge clkout) begin
        if (rst || core_rst) begin
            ready <= 1'b0;
        end else begin
            ready <= ren || wen;
        end
    end

    // what the access was, used only while ready is high
    always_ff @(posedge clkout) begin
        if (ren || wen) begin
            region_q <= region;
            offset_q <= data_addr[3:2];
            read_q   <= ren;
        end
    end

    // pick the registered word of the region that was addressed
    always_comb begin
        read_word = '0;
        case (region_q)
            REGION_MEM:  read_word = mem_rdata;
            REGION_BTN:  read_word = btn_rdata;
            REGION_UART: read_word = uart_rdata;
            REGION_TIMER: begin
                // offset 0 fast count, offset 1 slow count
                if (offset_q == 2'd0) begin
                    read_word = timer_fast;
                end else if (offset_q == 2'd1) begin
                    read_word = timer_slow;
                end
            end
            default: read_word = '0;
        endcase
    end

    // writes and unmapped reads return zero
    assign rdata = (ready && read_q) ? read_word : '0;

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // data address bits 31..28 select the region
    typedef enum logic [3:0] {
        REGION_MEM   = 4'h0,
        REGION_BTN   = 4'h1,
        REGION_UART  = 4'h2,
        REGION_TIMER = 4'h3,
        // stands for every unmapped code
        REGION_NONE  = 4'hf
    } region_e;

    // one bus word, seen whole or as byte lanes
    // lane 0 is bits 7..0
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;
    } bus_word_u;

    // boot memory depth in words, as address bits
    localparam int unsigned MEM_WORDS_BITS = 10;

    // timer prescalers, full rate and 27 MHz down to 1 MHz
    localparam int unsigned TIMER_FAST_DIV = 1;
    localparam int unsigned TIMER_SLOW_DIV = 27;

    // uart bit time in clocks
    localparam int unsigned UART_CLKS_PER_BIT = 16;

    // clean cycles needed before core reset releases
    localparam int unsigned DEBOUNCE_CYCLES = 64;

endpackage

`default_nettype wire
